/* dv/sd_card_model.sv */
`include "sd_cmd_defs.svh"

// Card side of the CMD line that captures each command and answers 48-bit ones
module sd_card_model (
    input  logic                    clk_fast,
    input  logic                    cmd_out,
    input  logic                    cmd_oe,
    input  logic                    cmd_done,
    input  sd_cmd_pkg::resp_type_e  resp_type,
    input  sd_cmd_pkg::sd_content_t resp_body,
    input  logic [1:0]              corrupt,
    output logic                    cmd_in,
    output sd_cmd_pkg::sd_frame_t   cap_frame,
    output int                      oe_cycles
);
    timeunit 1ns;
    timeprecision 1ps;

    int seed;
    logic oe_prev;

    // Corruption 1 flips the CRC LSB and 2 clears the end bit
    task automatic send_response();
        sd_cmd_pkg::sd_frame_t frame;
        int delay;
        frame = {resp_body, sd_cmd_pkg::crc7_of(resp_body), 1'b1};
        if (corrupt == 2'd1) begin
            frame[1] = ~frame[1];
        end else if (corrupt == 2'd2) begin
            frame[0] = 1'b0;
        end
        delay = 3 + ($unsigned($random(seed)) % 8);
        repeat (delay) @(posedge clk_fast);
        for (int i = `SD_FRAME_W - 1; i >= 0; i--) begin
            #1;
            cmd_in = frame[i];
            @(posedge clk_fast);
        end
        #1;
        cmd_in = 1'b1;
    endtask

    initial begin
        seed = 12;
        cmd_in = 1'b1;
        cap_frame = '0;
        oe_cycles = 0;
        oe_prev = 1'b0;
        forever begin
            @(negedge clk_fast);
            if (cmd_oe) begin
                // Rising cmd_oe opens a new capture
                if (!oe_prev) begin
                    cap_frame = '0;
                    oe_cycles = 0;
                end
                cap_frame = {cap_frame[`SD_FRAME_W-2:0], cmd_out};
                oe_cycles++;
            end
            oe_prev = cmd_oe;
            if (cmd_done && resp_type == sd_cmd_pkg::RESP_48) begin
                send_response();
            end
        end
    end

endmodule

/* dv/tb_sd_cmd_ctrl.sv */
`include "sd_cmd_defs.svh"

module tb_sd_cmd_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS = 7;
    localparam int CYCLE_LIMIT = NUM_ROWS * 150 + 100;
    // Same encoding as the card model
    localparam logic [1:0] CORR_NONE = 2'd0;
    localparam logic [1:0] CORR_CRC = 2'd1;
    localparam logic [1:0] CORR_END = 2'd2;

    typedef struct packed {
        logic [`SD_CONTENT_W-1:0] body;
        sd_cmd_pkg::resp_type_e   rtype;
        logic [`SD_CONTENT_W-1:0] resp_body;
        logic [1:0]               corrupt;
        logic                     exp_crc_err;
        logic                     exp_end_err;
        logic                     late_start;
    } row_t;

    logic clk_fast;
    logic rst_n;
    logic cmd_start;
    sd_cmd_pkg::sd_content_t cmd_body;
    sd_cmd_pkg::resp_type_e resp_type;
    logic cmd_out;
    logic cmd_oe;
    logic cmd_in;
    logic cmd_done;
    logic resp_done;
    sd_cmd_pkg::sd_frame_t resp_data;
    logic resp_crc_err;
    logic resp_end_err;

    sd_cmd_pkg::sd_content_t resp_body;
    logic [1:0] corrupt;
    sd_cmd_pkg::sd_frame_t cap_frame;
    int oe_cycles;

    row_t rows [NUM_ROWS];
    int row_errors;
    int current_row;
    int pass_count;
    int fail_count;
    int cycle_count;

    sd_cmd_ctrl DUT (
        .clk_fast     (clk_fast),
        .rst_n        (rst_n),
        .cmd_start    (cmd_start),
        .cmd_body     (cmd_body),
        .resp_type    (resp_type),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe),
        .cmd_in       (cmd_in),
        .cmd_done     (cmd_done),
        .resp_done    (resp_done),
        .resp_data    (resp_data),
        .resp_crc_err (resp_crc_err),
        .resp_end_err (resp_end_err)
    );

    sd_card_model u_card (
        .clk_fast  (clk_fast),
        .cmd_out   (cmd_out),
        .cmd_oe    (cmd_oe),
        .cmd_done  (cmd_done),
        .resp_type (resp_type),
        .resp_body (resp_body),
        .corrupt   (corrupt),
        .cmd_in    (cmd_in),
        .cap_frame (cap_frame),
        .oe_cycles (oe_cycles)
    );

    initial begin
        clk_fast = 1'b0;
        forever #5 clk_fast = ~clk_fast;
    end

    // ==============================
    // Helpers
    // ==============================

    // Shift-register form of x^7 + x^3 + 1 stepped one bit at a time
    function automatic logic [6:0] crc7_serial(input logic [`SD_CONTENT_W-1:0] data);
        logic [6:0] c;
        logic fb;
        c = 7'd0;
        for (int i = `SD_CONTENT_W - 1; i >= 0; i--) begin
            fb = data[i] ^ c[6];
            c = {c[5:3], c[2] ^ fb, c[1:0], fb};
        end
        return c;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAILED %0t: test %0d %s", $time, current_row, msg);
        row_errors++;
    endtask

    task automatic report_missing(input string msg);
        $display("Test %0d went wrong: %s", current_row, msg);
        row_errors++;
    endtask

    // Response bodies start with the 0 start bit and 0 transmission bit
    task automatic load_table();
        rows[0] = '{40'h40_0000_0000, sd_cmd_pkg::RESP_NONE, 40'h0,
                    CORR_NONE, 1'b0, 1'b0, 1'b0};
        rows[1] = '{40'h48_0000_01AA, sd_cmd_pkg::RESP_48, 40'h08_0000_01AA,
                    CORR_NONE, 1'b0, 1'b0, 1'b0};
        rows[2] = '{40'h77_0000_0000, sd_cmd_pkg::RESP_48, 40'h37_0000_0120,
                    CORR_NONE, 1'b0, 1'b0, 1'b0};
        rows[3] = '{40'h51_0000_1000, sd_cmd_pkg::RESP_48, 40'h11_0000_0900,
                    CORR_CRC, 1'b1, 1'b0, 1'b0};
        rows[4] = '{40'h4D_1234_0000, sd_cmd_pkg::RESP_48, 40'h0D_0000_0900,
                    CORR_END, 1'b0, 1'b1, 1'b0};
        rows[5] = '{40'h44_5678_0000, sd_cmd_pkg::RESP_NONE, 40'h0,
                    CORR_NONE, 1'b0, 1'b0, 1'b0};
        rows[6] = '{40'h50_0000_0200, sd_cmd_pkg::RESP_48, 40'h10_0000_0900,
                    CORR_NONE, 1'b0, 1'b0, 1'b1};
    endtask

    // ==============================
    // One table row
    // ==============================

    task automatic run_row(input int idx);
        row_t r;
        logic [`SD_FRAME_W-1:0] exp_cmd;
        logic [`SD_FRAME_W-1:0] exp_resp;
        logic oe_prev;
        int n;
        int limit;
        int done_cnt;
        int resp_cnt;
        r = rows[idx];
        current_row = idx;
        row_errors = 0;
        exp_cmd = {r.body, crc7_serial(r.body), 1'b1};
        exp_resp = {r.resp_body, crc7_serial(r.resp_body), 1'b1};
        if (r.corrupt == CORR_CRC) begin
            exp_resp[1] = ~exp_resp[1];
        end else if (r.corrupt == CORR_END) begin
            exp_resp[0] = 1'b0;
        end

        @(posedge clk_fast);
        #1;
        cmd_body = r.body;
        resp_type = r.rtype;
        resp_body = r.resp_body;
        corrupt = r.corrupt;
        cmd_start = 1'b1;
        done_cnt = 0;
        resp_cnt = 0;
        oe_prev = 1'b0;
        n = 0;
        // Command phase up to cmd_done
        while (done_cnt == 0 && n < 70) begin
            @(posedge clk_fast);
            #1;
            n++;
            cmd_start = r.late_start && n == 10;
            if (r.late_start && n == 10) begin
                cmd_body = ~r.body;
            end
            if (resp_done) begin
                report_mismatch("resp_done while the command is sent");
            end
            if (cmd_done) begin
                done_cnt++;
                if (cmd_oe || !oe_prev) begin
                    report_mismatch("cmd_done not in the cycle after cmd_oe fell");
                end
            end
            oe_prev = cmd_oe;
        end
        if (done_cnt == 0) begin
            report_missing("no cmd_done within 70 cycles of the start");
        end
        if (oe_cycles != `SD_FRAME_W) begin
            report_mismatch($sformatf("cmd_oe high for %0d cycles, expected 48", oe_cycles));
        end
        if (cap_frame != exp_cmd) begin
            report_mismatch($sformatf("command frame %h, expected %h", cap_frame, exp_cmd));
        end

        // Response phase or a quiet window for commands without one
        limit = (r.rtype == sd_cmd_pkg::RESP_48) ? 100 : 20;
        n = 0;
        while (n < limit && resp_cnt == 0) begin
            @(posedge clk_fast);
            #1;
            n++;
            if (cmd_done || cmd_oe) begin
                report_mismatch("second command activity after cmd_done");
            end
            if (resp_done) begin
                resp_cnt++;
                if (r.rtype == sd_cmd_pkg::RESP_NONE) begin
                    report_mismatch("resp_done for a command without response");
                end else begin
                    if (resp_data != exp_resp) begin
                        report_mismatch($sformatf("resp_data %h, expected %h",
                                                  resp_data, exp_resp));
                    end
                    if (resp_crc_err != r.exp_crc_err) begin
                        report_mismatch($sformatf("resp_crc_err %b, expected %b",
                                                  resp_crc_err, r.exp_crc_err));
                    end
                    if (resp_end_err != r.exp_end_err) begin
                        report_mismatch($sformatf("resp_end_err %b, expected %b",
                                                  resp_end_err, r.exp_end_err));
                    end
                end
            end
        end
        if (r.rtype == sd_cmd_pkg::RESP_48 && resp_cnt == 0) begin
            report_missing("no resp_done within 100 cycles of cmd_done");
        end

        if (row_errors == 0) begin
            pass_count++;
            $display("Test %0d passed", idx);
        end else begin
            fail_count++;
            $display("Test %0d failed with %0d errors", idx, row_errors);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        rst_n = 1'b0;
        cmd_start = 1'b0;
        cmd_body = '0;
        resp_type = sd_cmd_pkg::RESP_NONE;
        resp_body = '0;
        corrupt = CORR_NONE;
        pass_count = 0;
        fail_count = 0;
        current_row = 0;
        row_errors = 0;
        load_table();
        repeat (4) @(posedge clk_fast);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Hard stop if a wait never ends
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_fast);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* include/sd_cmd_defs.svh */
`ifndef SD_CMD_DEFS_SVH
`define SD_CMD_DEFS_SVH

// ==============================
// Frame geometry
// ==============================

// Start bit, transmission bit, index and argument
`define SD_CONTENT_W 40
`define SD_CRC_W 7
// Body, CRC7 and end bit
`define SD_FRAME_W 48

// ==============================
// Line constants
// ==============================

// x^7 + x^3 + 1, zero seed, MSB first
`define SD_CRC7_POLY 7'h09

// Cycles the CMD input is forced high after our driver releases the line
`define SD_TURNAROUND 2

`endif

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_sd_cmd_ctrl -o sim_tb > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

/* tb.f */
+incdir+include
verilog/sd_cmd_pkg.sv
verilog/resp_frame_if.sv
verilog/cmd_serializer.sv
verilog/resp_receiver.sv
verilog/resp_checker.sv
verilog/sd_cmd_ctrl.sv
dv/sd_card_model.sv
dv/tb_sd_cmd_ctrl.sv

/* verilog/cmd_serializer.sv */
`include "sd_cmd_defs.svh"

module cmd_serializer (
    input  logic                    clk_fast,
    input  logic                    rst_n,
    input  logic                    cmd_start,
    input  sd_cmd_pkg::sd_content_t cmd_body,
    input  sd_cmd_pkg::resp_type_e  resp_type,
    output logic                    cmd_out,
    output logic                    cmd_oe,
    output logic                    cmd_done,
    output logic                    resp_arm
);

    localparam int CNT_W = $clog2(`SD_FRAME_W);

    sd_cmd_pkg::ser_state_e state;
    sd_cmd_pkg::resp_type_e resp_q;
    logic [CNT_W-1:0] bit_cnt;
    sd_cmd_pkg::sd_frame_t shift_q;

    logic start_ok;

    // Starts outside idle are dropped
    assign start_ok = cmd_start && (state == sd_cmd_pkg::SER_IDLE);

    // ==============================
    // Control FSM
    // ==============================

    always_ff @(posedge clk_fast) begin
        if (!rst_n) begin
            state   <= sd_cmd_pkg::SER_IDLE;
            resp_q  <= sd_cmd_pkg::RESP_NONE;
            bit_cnt <= '0;
        end else begin
            case (state)
                sd_cmd_pkg::SER_IDLE: begin
                    if (start_ok) begin
                        resp_q  <= resp_type;
                        bit_cnt <= CNT_W'(`SD_FRAME_W - 1);
                        state   <= sd_cmd_pkg::SER_SHIFT;
                    end
                end

                sd_cmd_pkg::SER_SHIFT: begin
                    if (bit_cnt == '0) begin
                        state <= sd_cmd_pkg::SER_DONE;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end

                // One cycle for the done and arm pulses
                sd_cmd_pkg::SER_DONE: begin
                    state <= sd_cmd_pkg::SER_IDLE;
                end

                default: begin
                    state <= sd_cmd_pkg::SER_IDLE;
                end
            endcase
        end
    end

    // ==============================
    // Frame shift register
    // ==============================

    always_ff @(posedge clk_fast) begin
        if (start_ok) begin
            shift_q <= {cmd_body, sd_cmd_pkg::crc7_of(cmd_body), 1'b1};
        end else if (state == sd_cmd_pkg::SER_SHIFT) begin
            shift_q <= {shift_q[`SD_FRAME_W-2:0], 1'b1};
        end
    end

    assign cmd_oe   = (state == sd_cmd_pkg::SER_SHIFT);
    // Idle line level is high
    assign cmd_out  = cmd_oe ? shift_q[`SD_FRAME_W-1] : 1'b1;
    assign cmd_done = (state == sd_cmd_pkg::SER_DONE);
    assign resp_arm = cmd_done && (resp_q == sd_cmd_pkg::RESP_48);

    // ==============================
    // Assertions
    // ==============================

    // Full frame on the wire, then done right after release
    property p_oe_window;
        @(posedge clk_fast) disable iff (!rst_n)
            start_ok |=> cmd_oe [*`SD_FRAME_W] ##1 (!cmd_oe && cmd_done);
    endproperty
    a_oe_window: assert property (p_oe_window);

    property p_done_not_driving;
        @(posedge clk_fast) disable iff (!rst_n)
            cmd_done |-> !cmd_oe && $past(cmd_oe);
    endproperty
    a_done_not_driving: assert property (p_done_not_driving);

endmodule

/* verilog/resp_checker.sv */
module resp_checker (
    input  logic                  clk_fast,
    input  logic                  rst_n,
    resp_frame_if.chk             frm,
    output logic                  resp_done,
    output sd_cmd_pkg::sd_frame_t resp_data,
    output logic                  resp_crc_err,
    output logic                  resp_end_err
);

    logic crc_bad;

    assign crc_bad = (sd_cmd_pkg::crc7_of(frm.body) != frm.crc);

    // ==============================
    // Result registers
    // ==============================

    always_ff @(posedge clk_fast) begin
        if (!rst_n) begin
            resp_done    <= 1'b0;
            resp_crc_err <= 1'b0;
            resp_end_err <= 1'b0;
        end else begin
            resp_done <= frm.frame_valid;
            if (frm.frame_valid) begin
                resp_crc_err <= crc_bad;
                resp_end_err <= !frm.end_bit;
            end
        end
    end

    // Held until the next frame
    always_ff @(posedge clk_fast) begin
        if (frm.frame_valid) begin
            resp_data <= {frm.body, frm.crc, frm.end_bit};
        end
    end

    // Result comes one cycle behind the receiver, never on its own
    property p_done_after_valid;
        @(posedge clk_fast) disable iff (!rst_n)
            frm.frame_valid |=> resp_done;
    endproperty
    a_done_after_valid: assert property (p_done_after_valid);

    property p_done_has_frame;
        @(posedge clk_fast) disable iff (!rst_n)
            resp_done |-> $past(frm.frame_valid);
    endproperty
    a_done_has_frame: assert property (p_done_has_frame);

endmodule

/* verilog/resp_frame_if.sv */
// One received response frame, valid for a single cycle
interface resp_frame_if;

    logic frame_valid;
    sd_cmd_pkg::sd_content_t body;
    sd_cmd_pkg::sd_crc7_t crc;
    logic end_bit;

    modport receiver (
        output frame_valid,
        output body,
        output crc,
        output end_bit
    );

    modport chk (
        input frame_valid,
        input body,
        input crc,
        input end_bit
    );

endinterface

/* verilog/resp_receiver.sv */
`include "sd_cmd_defs.svh"

module resp_receiver (
    input  logic          clk_fast,
    input  logic          rst_n,
    input  logic          resp_arm,
    input  logic          cmd_in,
    resp_frame_if.receiver frm
);

    localparam int CNT_W   = $clog2(`SD_FRAME_W);
    localparam int GUARD_W = $clog2(`SD_TURNAROUND + 1);

    sd_cmd_pkg::rcv_state_e state;
    logic [GUARD_W-1:0] guard_cnt;
    logic [CNT_W-1:0] bit_cnt;
    logic line_q;
    sd_cmd_pkg::sd_frame_t shift_q;

    logic take_bit;

    // ==============================
    // Turnaround guard
    // ==============================

    // Line reads as idle while the card takes over the CMD line
    always_ff @(posedge clk_fast) begin
        if (!rst_n) begin
            guard_cnt <= '0;
            line_q    <= 1'b1;
        end else begin
            if (resp_arm) begin
                guard_cnt <= GUARD_W'(`SD_TURNAROUND);
            end else if (guard_cnt != '0) begin
                guard_cnt <= guard_cnt - 1'b1;
            end
            line_q <= (resp_arm || guard_cnt != '0) ? 1'b1 : cmd_in;
        end
    end

    // ==============================
    // Collector FSM
    // ==============================

    always_ff @(posedge clk_fast) begin
        if (!rst_n) begin
            state   <= sd_cmd_pkg::RCV_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                sd_cmd_pkg::RCV_IDLE: begin
                end

                // Start bit of the response
                sd_cmd_pkg::RCV_WAIT: begin
                    if (!line_q) begin
                        bit_cnt <= CNT_W'(`SD_FRAME_W - 2);
                        state   <= sd_cmd_pkg::RCV_COLLECT;
                    end
                end

                sd_cmd_pkg::RCV_COLLECT: begin
                    if (bit_cnt == '0) begin
                        state <= sd_cmd_pkg::RCV_DONE;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end

                sd_cmd_pkg::RCV_DONE: begin
                    state <= sd_cmd_pkg::RCV_IDLE;
                end

                default: begin
                    state <= sd_cmd_pkg::RCV_IDLE;
                end
            endcase

            // A fresh arm restarts a pending collection
            if (resp_arm) begin
                state <= sd_cmd_pkg::RCV_WAIT;
            end
        end
    end

    assign take_bit = (state == sd_cmd_pkg::RCV_COLLECT) ||
                      (state == sd_cmd_pkg::RCV_WAIT && !line_q);

    always_ff @(posedge clk_fast) begin
        if (take_bit) begin
            shift_q <= {shift_q[`SD_FRAME_W-2:0], line_q};
        end
    end

    assign frm.frame_valid = (state == sd_cmd_pkg::RCV_DONE);
    assign frm.body        = shift_q[`SD_FRAME_W-1 -: `SD_CONTENT_W];
    assign frm.crc         = shift_q[`SD_CRC_W:1];
    assign frm.end_bit     = shift_q[0];

    // Frame only ever comes straight out of a completed collection
    property p_valid_after_collect;
        @(posedge clk_fast) disable iff (!rst_n)
            frm.frame_valid |-> $past(state) == sd_cmd_pkg::RCV_COLLECT;
    endproperty
    a_valid_after_collect: assert property (p_valid_after_collect);

endmodule

/* verilog/sd_cmd_ctrl.sv */
module sd_cmd_ctrl (
    input  logic                    clk_fast,
    input  logic                    rst_n,
    input  logic                    cmd_start,
    input  sd_cmd_pkg::sd_content_t cmd_body,
    input  sd_cmd_pkg::resp_type_e  resp_type,
    output logic                    cmd_out,
    output logic                    cmd_oe,
    input  logic                    cmd_in,
    output logic                    cmd_done,
    output logic                    resp_done,
    output sd_cmd_pkg::sd_frame_t   resp_data,
    output logic                    resp_crc_err,
    output logic                    resp_end_err
);

    logic resp_arm;

    resp_frame_if frm ();

    // ==============================
    // Command out
    // ==============================

    cmd_serializer u_serializer (
        .clk_fast  (clk_fast),
        .rst_n     (rst_n),
        .cmd_start (cmd_start),
        .cmd_body  (cmd_body),
        .resp_type (resp_type),
        .cmd_out   (cmd_out),
        .cmd_oe    (cmd_oe),
        .cmd_done  (cmd_done),
        .resp_arm  (resp_arm)
    );

    // ==============================
    // Response in
    // ==============================

    resp_receiver u_receiver (
        .clk_fast (clk_fast),
        .rst_n    (rst_n),
        .resp_arm (resp_arm),
        .cmd_in   (cmd_in),
        .frm      (frm)
    );

    resp_checker u_checker (
        .clk_fast     (clk_fast),
        .rst_n        (rst_n),
        .frm          (frm),
        .resp_done    (resp_done),
        .resp_data    (resp_data),
        .resp_crc_err (resp_crc_err),
        .resp_end_err (resp_end_err)
    );

endmodule

/* verilog/sd_cmd_pkg.sv */
`include "sd_cmd_defs.svh"

package sd_cmd_pkg;

    // ==============================
    // Vector types
    // ==============================

    typedef logic [`SD_CONTENT_W-1:0] sd_content_t;
    typedef logic [`SD_CRC_W-1:0] sd_crc7_t;
    typedef logic [`SD_FRAME_W-1:0] sd_frame_t;

    // ==============================
    // Enums
    // ==============================

    typedef enum logic {
        RESP_NONE = 1'b0,
        RESP_48   = 1'b1
    } resp_type_e;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_SHIFT,
        SER_DONE
    } ser_state_e;

    typedef enum logic [1:0] {
        RCV_IDLE,
        RCV_WAIT,
        RCV_COLLECT,
        RCV_DONE
    } rcv_state_e;

    // Serial CRC7 over a 40-bit body, MSB first
    function automatic sd_crc7_t crc7_of(input sd_content_t body);
        sd_crc7_t crc;
        logic fb;
        crc = '0;
        for (int i = `SD_CONTENT_W - 1; i >= 0; i--) begin
            fb = body[i] ^ crc[`SD_CRC_W-1];
            crc = {crc[`SD_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ `SD_CRC7_POLY;
            end
        end
        return crc;
    endfunction

endpackage
